// File: Bender.yml
package:
  name: vtp

sources:
  - files:
      - hdl/vtp_pkg.sv
      - hdl/vtp_tlb_if.sv
      - hdl/vtp_fifo.sv
      - hdl/vtp_svc_pipe.sv
      - hdl/vtp_tlb.sv
      - hdl/vtp_page_walker.sv
      - hdl/vtp_top.sv

  - target: simulation
    files:
      - sim/vtp_props.sv
      - sim/tb_vtp_top.sv

// File: compile.f
hdl/vtp_pkg.sv
hdl/vtp_tlb_if.sv
hdl/vtp_fifo.sv
hdl/vtp_svc_pipe.sv
hdl/vtp_tlb.sv
hdl/vtp_page_walker.sv
hdl/vtp_top.sv
sim/vtp_props.sv
sim/tb_vtp_top.sv

// File: hdl/vtp_fifo.sv
`timescale 1ns/100ps

module vtp_fifo
#(
    parameter int DATA_BITS = 32,
    parameter int DEPTH = 2,
    parameter int THRESHOLD = 0
)
(
    input  logic clk,
    input  logic reset,

    input  logic [DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,

    output logic [DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    // Circular buffer with separate read and write pointers
    logic [DATA_BITS-1:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr_q] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end
        else
        begin
            // Pointers wrap at DEPTH even when it is not a power of two
            if (enq_en)
            begin
                wr_ptr_q <= (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end

            if (deq_en)
            begin
                rd_ptr_q <= (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end

            case ({enq_en, deq_en})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // The head is read straight from storage, so a write shows up next cycle
    assign first = mem[rd_ptr_q];
    assign not_empty = (count_q != '0);

    // Not full drops while THRESHOLD slots are still free, leaving room
    // for writers that already decided to enqueue
    assign not_full = (count_q < (DEPTH - THRESHOLD));

endmodule

// File: hdl/vtp_page_walker.sv
`timescale 1ns/100ps

module vtp_page_walker
    import vtp_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Walk request from the TLB
    input  logic walk_req,
    input  logic [VA_PAGE_BITS-1:0] walk_page_va,
    output logic walk_busy,

    // Fill back to the TLB
    output logic fill_en,
    output t_vtp_pt_entry fill_entry,

    // Page table load port
    input  logic pt_wr_en,
    input  logic [PT_INDEX_BITS-1:0] pt_wr_index,
    input  t_vtp_pt_entry pt_wr_entry
);

    t_vtp_pt_entry page_table [2**PT_INDEX_BITS];

    logic busy_q;
    logic [WALK_CNT_BITS-1:0] cnt_q;
    logic [VA_PAGE_BITS-1:0] va_q;
    t_vtp_pt_entry rd_entry_q;
    logic walk_done;

    always_ff @(posedge clk)
    begin
        if (pt_wr_en)
        begin
            page_table[pt_wr_index] <= pt_wr_entry;
        end
    end

    // ========================================
    // Walk sequencing
    // ========================================

    // The counter starts at WALK_LATENCY-1 so the fill lands
    // WALK_LATENCY cycles after the request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy_q <= 1'b0;
            cnt_q <= '0;
        end
        else if (!busy_q && walk_req)
        begin
            busy_q <= 1'b1;
            cnt_q <= WALK_CNT_BITS'(WALK_LATENCY - 1);
        end
        else if (walk_done)
        begin
            busy_q <= 1'b0;
        end
        else if (busy_q)
        begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy_q && walk_req)
        begin
            va_q <= walk_page_va;
        end

        // The slot is read every cycle, the last read before the fill counts
        rd_entry_q <= page_table[va_q[PT_INDEX_BITS-1:0]];
    end

    assign walk_done = busy_q && (cnt_q == '0);
    assign walk_busy = busy_q;

    // A slot holding some other page gives no fill, the lookup just retries
    assign fill_en = walk_done && vtp_entry_match(rd_entry_q, va_q);
    assign fill_entry = rd_entry_q;

endmodule

// File: hdl/vtp_pkg.sv
package vtp_pkg;

    // ========================================
    // Sizes
    // ========================================

    // A virtual page number addresses 4KB pages
    localparam int VA_PAGE_BITS = 24;
    localparam int PA_PAGE_BITS = 20;

    // 4KB page bits that fall inside one 2MB page
    localparam int BIG_PAGE_LOW_BITS = 9;
    localparam int BIG_FRAME_BITS = PA_PAGE_BITS - BIG_PAGE_LOW_BITS;

    localparam int TAG_BITS = 8;
    localparam int N_PORTS = 4;
    localparam int PORT_IDX_BITS = $clog2(N_PORTS);

    localparam int N_TLB_ENTRIES = 8;
    localparam int TLB_IDX_BITS = $clog2(N_TLB_ENTRIES);

    // The page table is indexed by the low bits of the virtual page
    localparam int PT_INDEX_BITS = 6;
    localparam int WALK_LATENCY = 4;
    localparam int WALK_CNT_BITS = $clog2(WALK_LATENCY);

    // Queue sizes inside the translation pipe
    localparam int IN_FIFO_DEPTH = 2;
    localparam int IN_FIFO_THRESHOLD = 1;
    localparam int ACTIVE_FIFO_DEPTH = 16;
    localparam int ACTIVE_FIFO_THRESHOLD = 3;

    // ========================================
    // Types
    // ========================================

    typedef struct packed {
        logic [VA_PAGE_BITS-1:0] page_va;
        logic [TAG_BITS-1:0] tag;
        logic [PORT_IDX_BITS-1:0] port;
    } t_vtp_lookup_req;

    typedef struct packed {
        logic [PA_PAGE_BITS-1:0] page_pa;
        logic [TAG_BITS-1:0] tag;
        logic [PORT_IDX_BITS-1:0] port;
        logic is_big_page;
    } t_vtp_lookup_rsp;

    // One stored frame word, read as a 4KB page or as a 2MB frame
    typedef union packed {
        logic [PA_PAGE_BITS-1:0] page_pa;
        struct packed {
            logic [BIG_FRAME_BITS-1:0] frame;
            logic [BIG_PAGE_LOW_BITS-1:0] unused;
        } big;
    } t_vtp_pt_frame;

    typedef struct packed {
        logic [VA_PAGE_BITS-1:0] va_tag;
        t_vtp_pt_frame frame;
        logic big;
        logic valid;
    } t_vtp_pt_entry;

    // A big entry ignores the 4KB page bits below the 2MB boundary
    function automatic logic vtp_entry_match(input t_vtp_pt_entry entry,
                                             input logic [VA_PAGE_BITS-1:0] page_va);
        logic same_big_page;
        logic same_page;
        same_big_page = (entry.va_tag[VA_PAGE_BITS-1:BIG_PAGE_LOW_BITS] ==
                         page_va[VA_PAGE_BITS-1:BIG_PAGE_LOW_BITS]);
        same_page = (entry.va_tag == page_va);
        return entry.valid && (entry.big ? same_big_page : same_page);
    endfunction

endpackage

// File: hdl/vtp_svc_pipe.sv
`timescale 1ns/100ps

module vtp_svc_pipe
    import vtp_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // New translation requests from the clients
    input  t_vtp_lookup_req req,
    input  logic req_en,
    output logic req_rdy,

    // Lookups toward the TLB
    vtp_tlb_if.client tlb,

    // Registered translation result
    output t_vtp_lookup_rsp rsp,
    output logic rsp_valid
);

    // ========================================
    // Input queue
    // ========================================

    t_vtp_lookup_req new_req;
    logic new_req_deq;
    logic new_req_rdy;

    // The port index travels inside the request struct
    vtp_fifo
    #(
        .DATA_BITS($bits(t_vtp_lookup_req)),
        .DEPTH(IN_FIFO_DEPTH),
        .THRESHOLD(IN_FIFO_THRESHOLD)
    )
    in_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_data(req),
        .enq_en(req_en),
        .not_full(req_rdy),
        .first(new_req),
        .deq_en(new_req_deq),
        .not_empty(new_req_rdy)
    );

    // ========================================
    // Active lookups
    // ========================================

    // Every issued lookup waits here until the TLB answers it.
    // Answers come back in issue order, so the head always belongs
    // to the current answer.
    t_vtp_lookup_req lookup_req;
    logic lookup_req_en;
    logic lookup_req_not_full;

    t_vtp_lookup_req active_head;
    logic active_not_empty;
    logic active_deq;

    vtp_fifo
    #(
        .DATA_BITS($bits(t_vtp_lookup_req)),
        .DEPTH(ACTIVE_FIFO_DEPTH),
        .THRESHOLD(ACTIVE_FIFO_THRESHOLD)
    )
    active_reqs
    (
        .clk(clk),
        .reset(reset),
        .enq_data(lookup_req),
        .enq_en(lookup_req_en),
        .not_full(lookup_req_not_full),
        .first(active_head),
        .deq_en(active_deq),
        .not_empty(active_not_empty)
    );

    // The head leaves on each answer, hit or miss
    assign active_deq = (tlb.lookup_rsp_valid || tlb.lookup_miss) && active_not_empty;

    // ========================================
    // Issue
    // ========================================

    // A new request waits while a miss is being looped back, while the
    // TLB is busy filling, or while the active queue is nearly full
    assign new_req_deq = new_req_rdy && lookup_req_not_full && tlb.lookup_rdy &&
                         !tlb.lookup_miss;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_req_en <= 1'b0;
        end
        else
        begin
            lookup_req_en <= tlb.lookup_miss || new_req_deq;
        end

        // A retry of the missed head wins over new work
        lookup_req <= tlb.lookup_miss ? active_head : new_req;
    end

    assign tlb.lookup_en = lookup_req_en;
    assign tlb.lookup_page_va = lookup_req.page_va;

    // ========================================
    // Response
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= tlb.lookup_rsp_valid;
        end

        // Tag and port come from the request the hit belongs to
        rsp.page_pa <= tlb.lookup_rsp_page_pa;
        rsp.tag <= active_head.tag;
        rsp.port <= active_head.port;
        rsp.is_big_page <= tlb.lookup_rsp_is_big_page;
    end

endmodule

// File: hdl/vtp_tlb.sv
`timescale 1ns/100ps

module vtp_tlb
    import vtp_pkg::*;
(
    input  logic clk,
    input  logic reset,

    vtp_tlb_if.tlb lk,

    // Page walk request and fill from the walker
    output logic walk_req,
    output logic [VA_PAGE_BITS-1:0] walk_page_va,
    input  logic walk_busy,
    input  logic fill_en,
    input  t_vtp_pt_entry fill_entry
);

    t_vtp_pt_entry entries [N_TLB_ENTRIES];
    logic [N_TLB_ENTRIES-1:0] entry_valid_q;
    logic [TLB_IDX_BITS-1:0] repl_idx_q;

    // A fill waits here until a cycle with no miss on the output
    logic fill_pend_q;
    t_vtp_pt_entry fill_pend_entry_q;
    logic fill_write;

    logic s1_valid_q;
    logic [VA_PAGE_BITS-1:0] s1_page_q;
    logic [N_TLB_ENTRIES-1:0] s1_hit_vec;
    logic s1_pend_hit;
    t_vtp_pt_entry s1_sel_entry;

    logic s2_valid_q;
    logic s2_hit_q;
    logic [VA_PAGE_BITS-1:0] s2_page_q;
    t_vtp_pt_frame s2_frame_q;
    logic s2_big_q;

    // ========================================
    // Stage one, tag compare
    // ========================================

    // The pending fill is compared too. A retry of the page that caused
    // the walk then hits, which opens a miss-free cycle for the write
    // even when retries keep the lookup port busy.
    always_comb
    begin
        s1_pend_hit = fill_pend_q && vtp_entry_match(fill_pend_entry_q, s1_page_q);
        s1_sel_entry = fill_pend_entry_q;
        for (int i = 0; i < N_TLB_ENTRIES; i++)
        begin
            s1_hit_vec[i] = entry_valid_q[i] && vtp_entry_match(entries[i], s1_page_q);
            if (s1_hit_vec[i])
            begin
                s1_sel_entry = entries[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end
        else
        begin
            s1_valid_q <= lk.lookup_en;
            s2_valid_q <= s1_valid_q;
        end

        s1_page_q <= lk.lookup_page_va;
        s2_page_q <= s1_page_q;
        s2_hit_q <= (|s1_hit_vec) || s1_pend_hit;
        s2_frame_q <= s1_sel_entry.frame;
        s2_big_q <= s1_sel_entry.big;
    end

    // ========================================
    // Stage two, answer
    // ========================================

    assign lk.lookup_rsp_valid = s2_valid_q && s2_hit_q;
    assign lk.lookup_miss = s2_valid_q && !s2_hit_q;
    assign lk.lookup_rsp_is_big_page = s2_big_q;

    // A big page keeps the 4KB page bits of the VA below its 2MB frame
    always_comb
    begin
        if (s2_big_q)
        begin
            lk.lookup_rsp_page_pa = {s2_frame_q.big.frame,
                                     s2_page_q[BIG_PAGE_LOW_BITS-1:0]};
        end
        else
        begin
            lk.lookup_rsp_page_pa = s2_frame_q.page_pa;
        end
    end

    // Only one walk is outstanding, including the wait for the write
    assign walk_req = lk.lookup_miss && !walk_busy && !fill_pend_q;
    assign walk_page_va = s2_page_q;

    // ========================================
    // Fill
    // ========================================

    // Writing never coincides with a miss, so a retry issued right after
    // a miss always saw the TLB ready
    assign fill_write = fill_pend_q && !lk.lookup_miss;
    assign lk.lookup_rdy = !fill_write;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fill_pend_q <= 1'b0;
            entry_valid_q <= '0;
            repl_idx_q <= '0;
        end
        else
        begin
            if (fill_en)
            begin
                fill_pend_q <= 1'b1;
            end
            else if (fill_write)
            begin
                fill_pend_q <= 1'b0;
            end

            // Victims are chosen round robin
            if (fill_write)
            begin
                entry_valid_q[repl_idx_q] <= 1'b1;
                repl_idx_q <= repl_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            fill_pend_entry_q <= fill_entry;
        end

        if (fill_write)
        begin
            entries[repl_idx_q] <= fill_pend_entry_q;
        end
    end

endmodule

// File: hdl/vtp_tlb_if.sv
`timescale 1ns/100ps

interface vtp_tlb_if
    import vtp_pkg::*;
;
    // Lookup request from the pipe
    logic lookup_en;
    logic [VA_PAGE_BITS-1:0] lookup_page_va;

    // Ready is sampled by the pipe one cycle before it raises lookup_en
    logic lookup_rdy;

    // In-order answer, either a hit with a translation or a miss
    logic lookup_rsp_valid;
    logic lookup_miss;
    logic [PA_PAGE_BITS-1:0] lookup_rsp_page_pa;
    logic lookup_rsp_is_big_page;

    modport client
    (
        output lookup_en,
        output lookup_page_va,
        input  lookup_rdy,
        input  lookup_rsp_valid,
        input  lookup_miss,
        input  lookup_rsp_page_pa,
        input  lookup_rsp_is_big_page
    );

    modport tlb
    (
        input  lookup_en,
        input  lookup_page_va,
        output lookup_rdy,
        output lookup_rsp_valid,
        output lookup_miss,
        output lookup_rsp_page_pa,
        output lookup_rsp_is_big_page
    );

endinterface

// File: hdl/vtp_top.sv
`timescale 1ns/100ps

module vtp_top
    import vtp_pkg::*;
(
    // Client lookup requests
    input  logic lookup_en,
    input  logic [VA_PAGE_BITS-1:0] lookup_page_va,
    input  logic [TAG_BITS-1:0] lookup_tag,
    input  logic [PORT_IDX_BITS-1:0] lookup_port,
    output logic lookup_rdy,

    // Translation results, one pulse each
    output logic rsp_valid,
    output logic [PA_PAGE_BITS-1:0] rsp_page_pa,
    output logic [TAG_BITS-1:0] rsp_tag,
    output logic [PORT_IDX_BITS-1:0] rsp_port,
    output logic rsp_is_big_page,

    // Page table load
    input  logic pt_wr_en,
    input  logic [PT_INDEX_BITS-1:0] pt_wr_index,
    input  t_vtp_pt_entry pt_wr_entry,

    input  logic clk,
    input  logic reset
);

    t_vtp_lookup_req req;
    t_vtp_lookup_rsp rsp;

    logic walk_req;
    logic [VA_PAGE_BITS-1:0] walk_page_va;
    logic walk_busy;
    logic fill_en;
    t_vtp_pt_entry fill_entry;

    vtp_tlb_if tlb_if ();

    assign req.page_va = lookup_page_va;
    assign req.tag = lookup_tag;
    assign req.port = lookup_port;

    assign rsp_page_pa = rsp.page_pa;
    assign rsp_tag = rsp.tag;
    assign rsp_port = rsp.port;
    assign rsp_is_big_page = rsp.is_big_page;

    vtp_svc_pipe u_pipe
    (
        .clk(clk),
        .reset(reset),
        .req(req),
        .req_en(lookup_en),
        .req_rdy(lookup_rdy),
        .tlb(tlb_if.client),
        .rsp(rsp),
        .rsp_valid(rsp_valid)
    );

    vtp_tlb u_tlb
    (
        .clk(clk),
        .reset(reset),
        .lk(tlb_if.tlb),
        .walk_req(walk_req),
        .walk_page_va(walk_page_va),
        .walk_busy(walk_busy),
        .fill_en(fill_en),
        .fill_entry(fill_entry)
    );

    vtp_page_walker u_walker
    (
        .clk(clk),
        .reset(reset),
        .walk_req(walk_req),
        .walk_page_va(walk_page_va),
        .walk_busy(walk_busy),
        .fill_en(fill_en),
        .fill_entry(fill_entry),
        .pt_wr_en(pt_wr_en),
        .pt_wr_index(pt_wr_index),
        .pt_wr_entry(pt_wr_entry)
    );

endmodule

// File: sim/tb_vtp_top.sv
`timescale 1ns/100ps

module tb_vtp_top
    import vtp_pkg::*;
;

    localparam int N_PAGES = 12;
    localparam int N_BURST = 120;
    localparam int N_TAGS = 2**TAG_BITS;
    localparam int RDY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 20000;
    // A hit is seen 6 cycles after the request is driven, a miss at least 9
    localparam int HIT_LATENCY_MAX = 7;

    logic clk;
    logic reset;
    logic lookup_en;
    logic [VA_PAGE_BITS-1:0] lookup_page_va;
    logic [TAG_BITS-1:0] lookup_tag;
    logic [PORT_IDX_BITS-1:0] lookup_port;
    logic lookup_rdy;
    logic rsp_valid;
    logic [PA_PAGE_BITS-1:0] rsp_page_pa;
    logic [TAG_BITS-1:0] rsp_tag;
    logic [PORT_IDX_BITS-1:0] rsp_port;
    logic rsp_is_big_page;
    logic pt_wr_en;
    logic [PT_INDEX_BITS-1:0] pt_wr_index;
    t_vtp_pt_entry pt_wr_entry;

    // Reference copy of the page table, one mapping per page
    logic [VA_PAGE_BITS-1:0] page_va [N_PAGES];
    logic [PA_PAGE_BITS-1:0] page_frame [N_PAGES];
    logic page_big [N_PAGES];

    // Outstanding requests, indexed by tag
    logic exp_pending [N_TAGS];
    logic [PA_PAGE_BITS-1:0] exp_pa [N_TAGS];
    logic [PORT_IDX_BITS-1:0] exp_port [N_TAGS];
    logic exp_big [N_TAGS];
    int exp_cycle [N_TAGS];

    logic [31:0] lfsr_state;
    int cycle_count;
    int sent_count;
    int rsp_count;
    int last_latency;
    int rdy_stalls;

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    vtp_top u_dut
    (
        .lookup_en(lookup_en),
        .lookup_page_va(lookup_page_va),
        .lookup_tag(lookup_tag),
        .lookup_port(lookup_port),
        .lookup_rdy(lookup_rdy),
        .rsp_valid(rsp_valid),
        .rsp_page_pa(rsp_page_pa),
        .rsp_tag(rsp_tag),
        .rsp_port(rsp_port),
        .rsp_is_big_page(rsp_is_big_page),
        .pt_wr_en(pt_wr_en),
        .pt_wr_index(pt_wr_index),
        .pt_wr_entry(pt_wr_entry),
        .clk(clk),
        .reset(reset)
    );

    // ========================================
    // Helpers
    // ========================================

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step for each bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // A 2MB page keeps the VA bits below its big frame
    function automatic logic [PA_PAGE_BITS-1:0] expected_pa(input int page,
                                                            input logic [VA_PAGE_BITS-1:0] va);
        if (page_big[page])
        begin
            return {page_frame[page][PA_PAGE_BITS-1:BIG_PAGE_LOW_BITS],
                    va[BIG_PAGE_LOW_BITS-1:0]};
        end
        return page_frame[page];
    endfunction

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // Low page bits are i*5 so every page owns its own walker slot.
    // The upper bits carry i so no big page covers another page.
    task automatic load_page_table();
        t_vtp_pt_entry entry;
        logic [10:0] high;
        logic [2:0] mid;
        for (int i = 0; i < N_PAGES; i++)
        begin
            high = 11'(take_bits(11));
            mid = 3'(take_bits(3));
            page_big[i] = (i % 3 == 0);
            page_va[i] = {high, 4'(i), mid, 6'(i * 5)};
            page_frame[i] = PA_PAGE_BITS'(take_bits(PA_PAGE_BITS));
            entry.va_tag = page_va[i];
            entry.frame.page_pa = page_frame[i];
            entry.big = page_big[i];
            entry.valid = 1'b1;
            @(posedge clk);
            pt_wr_en <= 1'b1;
            pt_wr_index <= PT_INDEX_BITS'(i * 5);
            pt_wr_entry <= entry;
        end
        @(posedge clk);
        pt_wr_en <= 1'b0;
    endtask

    // Inside a big page only the bits above the walker slot vary
    task automatic send_request(input int page, input logic [2:0] sub);
        logic [VA_PAGE_BITS-1:0] va;
        logic [TAG_BITS-1:0] tag;
        logic [PORT_IDX_BITS-1:0] port;
        int waited;
        va = page_va[page];
        if (page_big[page])
        begin
            va[BIG_PAGE_LOW_BITS-1:PT_INDEX_BITS] = sub;
        end
        tag = TAG_BITS'(sent_count);
        port = PORT_IDX_BITS'(take_bits(PORT_IDX_BITS));
        waited = 0;
        @(posedge clk);
        while (!lookup_rdy)
        begin
            lookup_en <= 1'b0;
            rdy_stalls++;
            waited++;
            if (waited > RDY_TIMEOUT)
            begin
                report_problem("Timed out waiting for lookup_rdy");
            end
            @(posedge clk);
        end
        exp_pa[tag] = expected_pa(page, va);
        exp_port[tag] = port;
        exp_big[tag] = page_big[page];
        exp_cycle[tag] = cycle_count;
        exp_pending[tag] = 1'b1;
        sent_count++;
        lookup_en <= 1'b1;
        lookup_page_va <= va;
        lookup_tag <= tag;
        lookup_port <= port;
    endtask

    task automatic wait_for_responses();
        int waited;
        waited = 0;
        @(posedge clk);
        lookup_en <= 1'b0;
        while (rsp_count != sent_count)
        begin
            waited++;
            if (waited > DRAIN_TIMEOUT)
            begin
                report_problem("Timed out waiting for all responses to return");
            end
            @(posedge clk);
        end
    endtask

    // ========================================
    // Checking
    // ========================================

    always @(posedge clk)
    begin
        if (!reset && rsp_valid)
        begin
            assert (exp_pending[rsp_tag])
            else report_mismatch($sformatf("unexpected response for tag %0d", rsp_tag));
            assert (rsp_page_pa == exp_pa[rsp_tag])
            else report_mismatch($sformatf("tag %0d page %h, expected %h",
                                           rsp_tag, rsp_page_pa, exp_pa[rsp_tag]));
            assert (rsp_port == exp_port[rsp_tag])
            else report_mismatch($sformatf("tag %0d port %0d, expected %0d",
                                           rsp_tag, rsp_port, exp_port[rsp_tag]));
            assert (rsp_is_big_page == exp_big[rsp_tag])
            else report_mismatch($sformatf("tag %0d big flag %b, expected %b",
                                           rsp_tag, rsp_is_big_page, exp_big[rsp_tag]));
            exp_pending[rsp_tag] = 1'b0;
            last_latency = cycle_count - exp_cycle[rsp_tag];
            rsp_count++;
        end
    end

    // The bound properties count their failures
    always @(posedge clk)
    begin
        if (u_dut.u_pipe.u_props.failures != 0)
        begin
            report_problem("A bound protocol property failed");
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    initial
    begin : main_seq
        logic [2:0] sub;
        int page;
        clk = 1'b0;
        reset = 1'b1;
        lookup_en = 1'b0;
        lookup_page_va = '0;
        lookup_tag = '0;
        lookup_port = '0;
        pt_wr_en = 1'b0;
        pt_wr_index = '0;
        pt_wr_entry = '0;
        lfsr_state = 32'haa9d;
        cycle_count = 0;
        sent_count = 0;
        rsp_count = 0;
        last_latency = 0;
        rdy_stalls = 0;
        for (int i = 0; i < N_TAGS; i++)
        begin
            exp_pending[i] = 1'b0;
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        load_page_table();

        // The TLB starts empty, so this 4KB lookup must go through a walk
        send_request(1, 3'b000);
        wait_for_responses();
        assert (last_latency > HIT_LATENCY_MAX)
        else report_mismatch("first lookup of a 4KB page did not miss");

        // Two VAs inside one 2MB page, the second one hits
        sub = 3'(take_bits(3));
        send_request(0, sub);
        wait_for_responses();
        send_request(0, sub ^ 3'b101);
        wait_for_responses();
        assert (last_latency <= HIT_LATENCY_MAX)
        else report_mismatch("second VA in the same 2MB page did not hit");

        // Back to back traffic over more pages than the TLB holds
        rdy_stalls = 0;
        for (int n = 0; n < N_BURST; n++)
        begin
            page = (n < N_PAGES) ? n : int'(take_bits(4)) % N_PAGES;
            sub = 3'(take_bits(3));
            send_request(page, sub);
        end
        wait_for_responses();
        assert (rdy_stalls > 0)
        else report_mismatch("lookup_rdy never dropped during the burst");

        repeat (10) @(posedge clk);
        if (u_dut.u_pipe.u_props.failures == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            stop_run();
        end
    end

endmodule

// File: sim/vtp_props.sv
`timescale 1ns/100ps

module vtp_props
(
    input logic clk,
    input logic reset,
    input logic lookup_en,
    input logic lookup_rdy,
    input logic lookup_rsp_valid,
    input logic lookup_miss,
    input logic rsp_valid
);

    // Number of property failures seen so far
    int failures = 0;

    // Every accepted lookup gets exactly one answer two cycles later
    lookup_answered: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> ##2 (lookup_rsp_valid ^ lookup_miss))
    else
    begin
        $error("Lookup without exactly one hit or miss two cycles later");
        failures++;
    end

    // No answer appears without a lookup two cycles before it
    answer_has_lookup: assert property (@(posedge clk) disable iff (reset)
        (lookup_rsp_valid || lookup_miss) |-> $past(lookup_en, 2))
    else
    begin
        $error("TLB answer without a matching lookup");
        failures++;
    end

    hit_miss_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(lookup_rsp_valid && lookup_miss))
    else
    begin
        $error("TLB reported hit and miss together");
        failures++;
    end

    // The pipe must have seen ready in the cycle before it issues
    issue_after_ready: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> $past(lookup_rdy))
    else
    begin
        $error("Lookup issued without ready seen the cycle before");
        failures++;
    end

    // Once a reset edge has passed, all control outputs sit idle
    idle_in_reset: assert property (@(posedge clk)
        reset |=> (!lookup_en && !lookup_rsp_valid && !lookup_miss && !rsp_valid && lookup_rdy))
    else
    begin
        $error("Control outputs not idle during reset");
        failures++;
    end

endmodule

bind vtp_svc_pipe vtp_props u_props
(
    .clk(clk),
    .reset(reset),
    .lookup_en(tlb.lookup_en),
    .lookup_rdy(tlb.lookup_rdy),
    .lookup_rsp_valid(tlb.lookup_rsp_valid),
    .lookup_miss(tlb.lookup_miss),
    .rsp_valid(rsp_valid)
);
